// File: rtl/mshr_coh_pkg.sv
package mshr_coh_pkg;

    // transient states of an outstanding miss
    // spx_i doubles as the free-entry marker
    typedef enum logic [2:0] {
        // free slot, also the reset value
        spx_i  = 3'd0,
        // waiting for shared data
        spx_is = 3'd1,
        // waiting for owned data
        spx_im = 3'd2,
        // upgrade in flight
        spx_sm = 3'd3,
        // eviction in flight
        spx_ii = 3'd4
    } unstable_state_t;

    // forwarded message kinds seen on the forward channel
    typedef enum logic [1:0] {
        // invalidate request from the home node
        fwd_inv   = 2'd0,
        // shared read forwarded from another requestor
        fwd_req_s = 2'd1,
        // ownership transfer forwarded from another requestor
        fwd_req_o = 2'd2
    } fwd_msg_t;

    // an invalidate that hits a line still in spx_is needs no stall
    // the incoming data is simply dropped once it lands
    // every other hit holds the forward until the miss retires

endpackage

// File: rtl/mshr_buf_pkg.sv
package mshr_buf_pkg;

    // address field widths
    localparam int tag_bits      = 12;
    localparam int set_bits      = 8;
    localparam int word_off_bits = 2;
    localparam int byte_off_bits = 2;

    // line geometry
    localparam int words_per_line = 4;
    localparam int word_bits      = 32;

    // widest entry index carried in the flag command
    localparam int idx_max_bits = 8;

    typedef logic [tag_bits+set_bits+word_off_bits+byte_off_bits-1:0] addr_t;

    // msb first, tag down to byte offset
    typedef struct packed {
        logic [tag_bits-1:0]      tag;
        logic [set_bits-1:0]      set;
        logic [word_off_bits-1:0] w_off;
        logic [byte_off_bits-1:0] b_off;
    } addr_fields_t;

    // same request word, raw or split into fields
    typedef union packed {
        addr_t        raw;
        addr_fields_t fields;
    } mshr_addr_u;

    typedef logic [words_per_line*word_bits-1:0] line_t;
    typedef logic [words_per_line-1:0]           word_mask_t;

    // one outstanding miss
    typedef struct packed {
        mshr_coh_pkg::unstable_state_t state;
        logic [tag_bits-1:0]           tag;
        logic [set_bits-1:0]           set;
        logic [word_off_bits-1:0]      w_off;
        logic [byte_off_bits-1:0]      b_off;
        line_t                         line;
        word_mask_t                    word_mask;
    } mshr_entry_t;

    // one command per cycle from the cache FSM
    typedef enum logic [1:0] {
        op_idle,
        op_lookup,
        op_peek_req,
        op_peek_fwd
    } mshr_op_t;

    // write strobes plus the values they carry
    typedef struct packed {
        logic                          add;
        logic                          upd_state;
        logic                          upd_line;
        logic                          upd_tag;
        logic                          upd_word_mask;
        mshr_coh_pkg::unstable_state_t state;
        logic [tag_bits-1:0]           tag;
        line_t                         line;
        word_mask_t                    word_mask;
    } mshr_upd_t;

    // set/clear pulses from the search to the sticky flags
    typedef struct packed {
        logic                    set_conflict_set;
        logic                    set_conflict_clr;
        logic                    fwd_stall_set;
        logic                    fwd_stall_clr;
        logic [idx_max_bits-1:0] stall_entry;
    } flag_cmd_t;

endpackage

// File: rtl/mshr_entry_array.sv
`timescale 1ns/10ps

module mshr_entry_array #(
    parameter int n_entries = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  mshr_buf_pkg::mshr_upd_t     upd,
    input  mshr_buf_pkg::mshr_addr_u    req_addr,
    input  logic [$clog2(n_entries)-1:0] mshr_i,
    output mshr_buf_pkg::mshr_entry_t   entries [n_entries]
);

    import mshr_coh_pkg::*;
    import mshr_buf_pkg::*;

    localparam int idx_bits = $clog2(n_entries);

    for (genvar i = 0; i < n_entries; i++) begin : g_entry
        logic                     sel;
        unstable_state_t          state_q;
        logic [tag_bits-1:0]      tag_q;
        logic [set_bits-1:0]      set_q;
        logic [word_off_bits-1:0] w_off_q;
        logic [byte_off_bits-1:0] b_off_q;
        line_t                    line_q;
        word_mask_t               word_mask_q;

        // writes only land on the slot picked by the last op
        assign sel = (mshr_i == idx_bits'(i));

        // address part, written on add only
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                set_q   <= '0;
                w_off_q <= '0;
                b_off_q <= '0;
            end else if (upd.add && sel) begin
                set_q   <= req_addr.fields.set;
                w_off_q <= req_addr.fields.w_off;
                b_off_q <= req_addr.fields.b_off;
            end
        end

        // state
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                state_q <= spx_i;
            end else if ((upd.add || upd.upd_state) && sel) begin
                state_q <= upd.state;
            end
        end

        // line data
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                line_q <= '0;
            end else if ((upd.add || upd.upd_line) && sel) begin
                line_q <= upd.line;
            end
        end

        // tag, from the update value and not from req_addr
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                tag_q <= '0;
            end else if ((upd.add || upd.upd_tag) && sel) begin
                tag_q <= upd.tag;
            end
        end

        // word mask
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                word_mask_q <= '0;
            end else if ((upd.add || upd.upd_word_mask) && sel) begin
                word_mask_q <= upd.word_mask;
            end
        end

        // pack the field groups back into one record
        assign entries[i] = '{
            state:     state_q,
            tag:       tag_q,
            set:       set_q,
            w_off:     w_off_q,
            b_off:     b_off_q,
            line:      line_q,
            word_mask: word_mask_q
        };
    end

endmodule

// File: rtl/mshr_search.sv
`timescale 1ns/10ps

module mshr_search #(
    parameter int n_entries = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  mshr_buf_pkg::mshr_op_t       op,
    input  mshr_buf_pkg::mshr_addr_u     req_addr,
    input  mshr_coh_pkg::fwd_msg_t       fwd_msg,
    input  mshr_buf_pkg::mshr_entry_t    entries [n_entries],
    output logic [$clog2(n_entries)-1:0] mshr_i,
    output logic                         mshr_hit,
    output mshr_buf_pkg::flag_cmd_t      flag_cmd
);

    import mshr_coh_pkg::*;
    import mshr_buf_pkg::*;

    localparam int idx_bits = $clog2(n_entries);

    logic [idx_bits-1:0] i_next;
    logic                hit_next;
    unstable_state_t     hit_state;
    logic                fwd_override;

    always_comb begin
        i_next       = '0;
        hit_next     = 1'b0;
        hit_state    = spx_i;
        fwd_override = 1'b0;
        flag_cmd     = '0;

        // ascending scan, so the highest qualifying index wins
        case (op)
            op_lookup: begin
                for (int i = 0; i < n_entries; i++) begin
                    if (entries[i].state != spx_i &&
                        entries[i].tag == req_addr.fields.tag &&
                        entries[i].set == req_addr.fields.set) begin
                        hit_next = 1'b1;
                        i_next   = idx_bits'(i);
                    end
                end
            end
            op_peek_req: begin
                // default to clear, any live entry on the same set overrides
                flag_cmd.set_conflict_clr = 1'b1;
                for (int i = 0; i < n_entries; i++) begin
                    // free slot, index 0 stays if none
                    if (entries[i].state == spx_i) begin
                        i_next = idx_bits'(i);
                    end
                    if (entries[i].state != spx_i &&
                        entries[i].set == req_addr.fields.set) begin
                        flag_cmd.set_conflict_set = 1'b1;
                        flag_cmd.set_conflict_clr = 1'b0;
                    end
                end
            end
            op_peek_fwd: begin
                for (int i = 0; i < n_entries; i++) begin
                    if (entries[i].state != spx_i &&
                        entries[i].tag == req_addr.fields.tag &&
                        entries[i].set == req_addr.fields.set) begin
                        hit_next  = 1'b1;
                        i_next    = idx_bits'(i);
                        hit_state = entries[i].state;
                    end
                end
                // inv racing our own shared fill goes straight through
                fwd_override = (fwd_msg == fwd_inv) && (hit_state == spx_is);
                if (hit_next && !fwd_override) begin
                    flag_cmd.fwd_stall_set = 1'b1;
                    flag_cmd.stall_entry   = idx_max_bits'(i_next);
                end else begin
                    flag_cmd.fwd_stall_clr = 1'b1;
                end
            end
            default: begin
                // idle, nothing to search
                hit_next = 1'b0;
            end
        endcase
    end

    // result of the op, visible the cycle after
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mshr_i   <= '0;
            mshr_hit <= 1'b0;
        end else if (op != op_idle) begin
            mshr_i   <= i_next;
            mshr_hit <= hit_next;
        end
    end

endmodule

// File: rtl/mshr_stall_flags.sv
`timescale 1ns/10ps

module mshr_stall_flags #(
    parameter int n_entries = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  mshr_buf_pkg::flag_cmd_t      flag_cmd,
    output logic                         set_conflict,
    output logic                         fwd_stall,
    output logic [$clog2(n_entries)-1:0] fwd_stall_entry
);

    import mshr_buf_pkg::*;

    localparam int idx_bits = $clog2(n_entries);

    // core holds off new cpu requests while this is up
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            set_conflict <= 1'b0;
        end else if (flag_cmd.set_conflict_set) begin
            set_conflict <= 1'b1;
        end else if (flag_cmd.set_conflict_clr) begin
            set_conflict <= 1'b0;
        end
    end

    // core holds the forward channel while this is up
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_stall <= 1'b0;
        end else if (flag_cmd.fwd_stall_set) begin
            fwd_stall <= 1'b1;
        end else if (flag_cmd.fwd_stall_clr) begin
            fwd_stall <= 1'b0;
        end
    end

    // entry the stalled forward waits on
    // kept across the clear so the core can still read it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_stall_entry <= '0;
        end else if (flag_cmd.fwd_stall_set) begin
            fwd_stall_entry <= flag_cmd.stall_entry[idx_bits-1:0];
        end
    end

endmodule

// File: rtl/l2_mshr.sv
`timescale 1ns/10ps

module l2_mshr #(
    parameter int n_entries = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  mshr_buf_pkg::mshr_op_t       op,
    input  mshr_buf_pkg::mshr_addr_u     req_addr,
    input  mshr_coh_pkg::fwd_msg_t       fwd_msg,
    input  mshr_buf_pkg::mshr_upd_t      upd,
    output logic                         mshr_hit,
    output logic [$clog2(n_entries)-1:0] mshr_i,
    output mshr_buf_pkg::mshr_entry_t    entry_rd,
    output logic                         set_conflict,
    output logic                         fwd_stall,
    output logic [$clog2(n_entries)-1:0] fwd_stall_entry
);

    import mshr_buf_pkg::*;

    // all entries, seen by the search and the read mux
    mshr_entry_t entries [n_entries];
    flag_cmd_t   flag_cmd;

    // storage, written at the index left by the last op
    mshr_entry_array #(
        .n_entries (n_entries)
    ) u_array (
        .clk      (clk),
        .rst      (rst),
        .upd      (upd),
        .req_addr (req_addr),
        .mshr_i   (mshr_i),
        .entries  (entries)
    );

    // op decode and parallel match
    mshr_search #(
        .n_entries (n_entries)
    ) u_search (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .req_addr (req_addr),
        .fwd_msg  (fwd_msg),
        .entries  (entries),
        .mshr_i   (mshr_i),
        .mshr_hit (mshr_hit),
        .flag_cmd (flag_cmd)
    );

    // sticky conflict and stall flags
    mshr_stall_flags #(
        .n_entries (n_entries)
    ) u_flags (
        .clk             (clk),
        .rst             (rst),
        .flag_cmd        (flag_cmd),
        .set_conflict    (set_conflict),
        .fwd_stall       (fwd_stall),
        .fwd_stall_entry (fwd_stall_entry)
    );

    // selected entry, follows mshr_i without a register
    assign entry_rd = entries[mshr_i];

endmodule

// File: bench/tb_l2_mshr.sv
`timescale 1ns/10ps

module tb_l2_mshr;

    import mshr_coh_pkg::*;
    import mshr_buf_pkg::*;

    localparam int n_entries   = 4;
    localparam int idx_bits    = $clog2(n_entries);
    localparam int max_lines   = 200;

    logic                clk;
    logic                rst;
    mshr_op_t            op;
    mshr_addr_u          req_addr;
    fwd_msg_t            fwd_msg;
    mshr_upd_t           upd;
    logic                mshr_hit;
    logic [idx_bits-1:0] mshr_i;
    mshr_entry_t         entry_rd;
    logic                set_conflict;
    logic                fwd_stall;
    logic [idx_bits-1:0] fwd_stall_entry;

    // shadow copy of the entries and of the registered results
    mshr_entry_t         sh [n_entries];
    logic [idx_bits-1:0] sh_i;
    logic                sh_hit;
    logic                sh_conf;
    logic                sh_stall;
    logic [idx_bits-1:0] sh_sentry;

    l2_mshr #(
        .n_entries (n_entries)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .op              (op),
        .req_addr        (req_addr),
        .fwd_msg         (fwd_msg),
        .upd             (upd),
        .mshr_hit        (mshr_hit),
        .mshr_i          (mshr_i),
        .entry_rd        (entry_rd),
        .set_conflict    (set_conflict),
        .fwd_stall       (fwd_stall),
        .fwd_stall_entry (fwd_stall_entry)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_hit(input logic got_hit, input logic [idx_bits-1:0] got_i,
                             input logic exp_hit, input logic [idx_bits-1:0] exp_i);
        if (got_hit !== exp_hit) begin
            $display("mismatch mshr_hit: got %h expected %h", got_hit, exp_hit);
            abort_run();
        end else if (got_i !== exp_i) begin
            $display("mismatch mshr_i: got %h expected %h", got_i, exp_i);
            abort_run();
        end
    endtask

    task automatic check_entry(input mshr_entry_t got, input mshr_entry_t exp);
        if (got !== exp) begin
            $display("mismatch entry_rd: got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags(input logic got_conf, input logic got_stall,
                               input logic [idx_bits-1:0] got_se, input logic exp_conf,
                               input logic exp_stall, input logic [idx_bits-1:0] exp_se);
        if (got_conf !== exp_conf) begin
            $display("mismatch set_conflict: got %h expected %h", got_conf, exp_conf);
            abort_run();
        end else if (got_stall !== exp_stall) begin
            $display("mismatch fwd_stall: got %h expected %h", got_stall, exp_stall);
            abort_run();
        end else if (got_se !== exp_se) begin
            $display("mismatch fwd_stall_entry: got %h expected %h", got_se, exp_se);
            abort_run();
        end
    endtask

    // one clock edge of the reference model
    // search sees the old contents and the write lands at the old index
    task automatic model_step(input mshr_op_t m_op, input mshr_addr_u a,
                              input fwd_msg_t f, input mshr_upd_t u);
        logic [idx_bits-1:0] idx;
        logic                hit;
        logic                conf;
        unstable_state_t     st;
        idx  = '0;
        hit  = 1'b0;
        conf = 1'b0;
        st   = spx_i;
        for (int k = 0; k < n_entries; k++) begin
            if (m_op == op_peek_req) begin
                if (sh[k].state == spx_i) begin
                    idx = idx_bits'(k);
                end else if (sh[k].set == a.fields.set) begin
                    conf = 1'b1;
                end
            end else if (sh[k].state != spx_i && sh[k].tag == a.fields.tag &&
                         sh[k].set == a.fields.set) begin
                hit = 1'b1;
                idx = idx_bits'(k);
                st  = sh[k].state;
            end
        end
        if (u.add) begin
            sh[sh_i] = '{state: u.state, tag: u.tag, set: a.fields.set, w_off: a.fields.w_off,
                         b_off: a.fields.b_off, line: u.line, word_mask: u.word_mask};
        end else begin
            if (u.upd_state) sh[sh_i].state = u.state;
            if (u.upd_line) sh[sh_i].line = u.line;
            if (u.upd_tag) sh[sh_i].tag = u.tag;
            if (u.upd_word_mask) sh[sh_i].word_mask = u.word_mask;
        end
        if (m_op == op_peek_req) begin
            sh_conf = conf;
        end
        // invalidate against a pending shared fill passes without a stall
        if (m_op == op_peek_fwd) begin
            sh_stall = hit && !(f == fwd_inv && st == spx_is);
            if (sh_stall) sh_sentry = idx;
        end
        if (m_op != op_idle) begin
            sh_i   = idx;
            sh_hit = (m_op == op_peek_req) ? 1'b0 : hit;
        end
    endtask

    initial begin
        int           fd;
        int           row;
        int           lines_read;
        int           n;
        string        text;
        logic [31:0]  f_op, f_addr, f_fwd, f_add, f_us, f_ul, f_ut, f_uw, f_state, f_tag;
        logic [127:0] f_line;
        logic [31:0]  f_wm, f_rnd, f_hit, f_i, f_conf, f_stall, f_se;
        void'($urandom(34249));
        rst      = 1'b0;
        op       = op_idle;
        req_addr = '0;
        fwd_msg  = fwd_inv;
        upd      = '0;
        for (int k = 0; k < n_entries; k++) sh[k] = '0;
        sh_i      = '0;
        sh_hit    = 1'b0;
        sh_conf   = 1'b0;
        sh_stall  = 1'b0;
        sh_sentry = '0;
        fd = $fopen("bench/l2_mshr_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/l2_mshr_testdata.txt");
            abort_run();
        end
        repeat (3) @(negedge clk);
        // async reset has cleared every registered output and every entry
        check_hit(mshr_hit, mshr_i, 1'b0, '0);
        check_flags(set_conflict, fwd_stall, fwd_stall_entry, 1'b0, 1'b0, '0);
        check_entry(entry_rd, '0);
        rst = 1'b1;
        row        = 0;
        lines_read = 0;
        while (lines_read < max_lines && $fgets(text, fd) != 0) begin
            lines_read++;
            if (text.len() < 2 || text[0] == "#") continue;
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_op, f_addr, f_fwd, f_add, f_us, f_ul, f_ut, f_uw, f_state, f_tag,
                        f_line, f_wm, f_rnd, f_hit, f_i, f_conf, f_stall, f_se);
            if (n != 18) begin
                $display("testdata line %0d is malformed", lines_read);
                abort_run();
            end
            row++;
            // inputs change on the falling edge
            op                 = mshr_op_t'(f_op[1:0]);
            req_addr.raw       = f_addr[23:0];
            fwd_msg            = fwd_msg_t'(f_fwd[1:0]);
            upd.add            = f_add[0];
            upd.upd_state      = f_us[0];
            upd.upd_line       = f_ul[0];
            upd.upd_tag        = f_ut[0];
            upd.upd_word_mask  = f_uw[0];
            upd.state          = unstable_state_t'(f_state[2:0]);
            upd.tag            = f_tag[tag_bits-1:0];
            upd.line           = f_rnd[0] ? {$urandom(), $urandom(), $urandom(), $urandom()}
                                          : f_line;
            upd.word_mask      = f_wm[words_per_line-1:0];
            model_step(op, req_addr, fwd_msg, upd);
            if (f_hit[0] !== sh_hit || f_i[idx_bits-1:0] !== sh_i ||
                f_conf[0] !== sh_conf || f_stall[0] !== sh_stall ||
                f_se[idx_bits-1:0] !== sh_sentry) begin
                $display("testdata row %0d disagrees with the shadow model", row);
                abort_run();
            end
            // results settle one edge later
            @(negedge clk);
            check_hit(mshr_hit, mshr_i, f_hit[0], f_i[idx_bits-1:0]);
            check_flags(set_conflict, fwd_stall, fwd_stall_entry, f_conf[0], f_stall[0],
                        f_se[idx_bits-1:0]);
            check_entry(entry_rd, sh[sh_i]);
        end
        $fclose(fd);
        if (row == 0) begin
            $display("testdata file held no records");
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: bench/l2_mshr_testdata.txt
# op addr fwd add upd_state upd_line upd_tag upd_wm state tag line wm rnd (stimulus, hex)
# then expected hit idx set_conflict fwd_stall fwd_stall_entry (hex)
1 123450 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 0 0 0
2 123450 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 3 0 0 0
0 123458 0 1 0 0 0 0 2 123 00000000000000000000000000000000 f 1  0 3 0 0 0
1 123450 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 3 0 0 0
2 123450 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 2 1 0 0
2 2ab670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 2 0 0 0
0 2ab670 0 1 0 0 0 0 1 2ab 0123456789abcdef0011223344556677 3 0  0 2 0 0 0
2 3cd890 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 1 0 0 0
0 3cd894 0 1 0 0 0 0 2 3cd 00000000000000000000000000000000 1 1  0 1 0 0 0
3 3cd890 1 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 1 0 1 1
0 000000 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 1 0 1 1
3 2ab670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 2 0 0 1
3 123450 2 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 3 0 1 3
3 777770 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 0 0 3
1 2ab670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 2 0 0 3
0 000000 0 0 0 1 0 0 3 fff aaaaaaaa55555555aaaaaaaa55555555 f 0  1 2 0 0 3
0 000000 0 0 1 0 0 0 3 fff 00000000000000000000000000000000 f 0  1 2 0 0 3
1 2ab670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 2 0 0 3
0 000000 0 0 0 0 1 0 0 2ac 00000000000000000000000000000000 0 0  1 2 0 0 3
1 2ab670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 0 0 3
1 2ac670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 2 0 0 3
0 000000 0 0 0 0 0 1 0 000 00000000000000000000000000000000 c 0  1 2 0 0 3
0 000000 0 0 1 0 0 0 0 000 00000000000000000000000000000000 0 0  1 2 0 0 3
1 2ac670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 0 0 3
2 2ac670 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 2 0 0 3
0 2ac670 0 1 0 0 0 0 4 2ac 00000000000000000000000000000000 2 1  0 2 0 0 3
2 456890 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 1 0 3
0 45689c 0 1 0 0 0 0 1 456 00000000ffffffff12345678deadbeef 8 0  0 0 1 0 3
2 999450 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 1 0 3
2 999ab0 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 0 0 3
0 000000 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  0 0 0 0 3
1 45689c 0 0 0 0 0 0 0 000 00000000000000000000000000000000 0 0  1 0 0 0 3

// File: l2_mshr.f
rtl/mshr_coh_pkg.sv
rtl/mshr_buf_pkg.sv
rtl/mshr_entry_array.sv
rtl/mshr_search.sv
rtl/mshr_stall_flags.sv
rtl/l2_mshr.sv
bench/tb_l2_mshr.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timescale 1ns/10ps
TOP      = tb_l2_mshr
FILELIST = l2_mshr.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
